//--- cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Word width of data and addresses
`define CPU_XLEN 32

// General-purpose register count
`define CPU_NREGS 32

// Register-number width
`define CPU_REG_AW 5

// Boot vector
`define CPU_RESET_PC 32'hbfc00000

// One strobe bit per byte lane
`define CPU_STRB_W 4

`endif

//--- cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

	// Major opcodes, inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,  // R-type, see funct
		OP_J       = 6'h02,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_e;

	// SPECIAL functions, inst[5:0]
	typedef enum logic [5:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,  // Also address add for LW/SW
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5,  // Signed compare
		ALU_LUI = 3'd6   // Immediate to upper half
	} alu_op_e;

	// Control of one instruction past decode
	typedef struct packed {
		alu_op_e                alu_op;
		logic                   use_imm;  // Operand 2 is the immediate
		logic                   rf_wen;   // Never set for register 0
		logic                   load;
		logic                   store;
		logic [`CPU_REG_AW-1:0] dest;
	} ctrl_t;

endpackage

//--- fwd_if.sv
`include "cpu_defs.svh"

// Pending register write of one stage
// wen marks a write in flight and valid marks its data as known
// A load before writeback has wen high and valid low
interface fwd_if;
	logic                   valid;  // Write data is ready
	logic                   wen;    // Stage holds a register write
	logic [`CPU_REG_AW-1:0] rnum;   // Destination register
	logic [`CPU_XLEN-1:0]   wdata;  // Value to be written

	modport src (
		output valid,
		output wen,
		output rnum,
		output wdata
	);

	modport dst (
		input valid,
		input wen,
		input rnum,
		input wdata
	);
endinterface

//--- reg_file.sv
`include "cpu_defs.svh"

module reg_file (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic [`CPU_REG_AW-1:0] i_raddr1,
	input  logic [`CPU_REG_AW-1:0] i_raddr2,
	output logic [`CPU_XLEN-1:0]   o_rdata1,
	output logic [`CPU_XLEN-1:0]   o_rdata2,
	fwd_if.dst                     i_wb
);
	logic [`CPU_XLEN-1:0] regs [1:`CPU_NREGS-1];  // No storage for register 0

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			for (int k = 1; k < `CPU_NREGS; k++)
				regs[k] <= '0;
		end
		else if (i_wb.valid && i_wb.wen && i_wb.rnum != '0)
			regs[i_wb.rnum] <= i_wb.wdata;  // Writeback port
	end

	// Same-cycle writes reach decode through the WB forward path
	assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
	assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

//--- fetch_stage.sv
`include "cpu_defs.svh"

module fetch_stage (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 i_id_allow_in,
	input  logic                 i_redirect,
	input  logic [`CPU_XLEN-1:0] i_target,
	output logic                 o_fetch_go,
	output logic [`CPU_XLEN-1:0] o_pc,
	output logic                 o_inst_sram_en,
	output logic [`CPU_XLEN-1:0] o_inst_sram_addr
);
	localparam logic [`CPU_XLEN-1:0] word_bytes = 4;

	logic [`CPU_XLEN-1:0] pc;       // Address being fetched
	logic [`CPU_XLEN-1:0] pc_next;

	// SRAM answers every request in one cycle
	assign o_fetch_go = i_id_allow_in;

	// While a branch sits in decode this PC is its delay slot
	assign pc_next = i_redirect ? i_target : pc + word_bytes;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			pc <= `CPU_RESET_PC;
		else if (o_fetch_go)
			pc <= pc_next;  // Frozen during load-use stall
	end

	assign o_pc             = pc;
	assign o_inst_sram_en   = o_fetch_go;
	assign o_inst_sram_addr = pc;

endmodule

//--- decode_stage.sv
`include "cpu_defs.svh"

module decode_stage (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   i_fetch_go,
	input  logic [`CPU_XLEN-1:0]   i_pc,
	input  logic [`CPU_XLEN-1:0]   i_inst,
	input  logic [`CPU_XLEN-1:0]   i_rdata1,
	input  logic [`CPU_XLEN-1:0]   i_rdata2,
	output logic [`CPU_REG_AW-1:0] o_raddr1,
	output logic [`CPU_REG_AW-1:0] o_raddr2,
	fwd_if.dst                     i_ex_fwd,
	fwd_if.dst                     i_mem_fwd,
	fwd_if.dst                     i_wb_fwd,
	input  logic                   i_ex_allow_in,
	output logic                   o_allow_in,
	output logic                   o_valid,
	output logic                   o_redirect,
	output logic [`CPU_XLEN-1:0]   o_target,
	output cpu_pkg::ctrl_t         o_ctrl,
	output logic [`CPU_XLEN-1:0]   o_pc,
	output logic [`CPU_XLEN-1:0]   o_op1,
	output logic [`CPU_XLEN-1:0]   o_op2,
	output logic [`CPU_XLEN-1:0]   o_imm
);
	import cpu_pkg::*;

	localparam logic [`CPU_XLEN-1:0] word_bytes = 4;

	logic                   id_valid;    // Decode holds an instruction
	logic                   id_go;       // Moves to execute this cycle
	logic [`CPU_XLEN-1:0]   pc_id;
	logic                   hold_valid;  // Word comes from hold register
	logic [`CPU_XLEN-1:0]   inst_hold;
	logic [`CPU_XLEN-1:0]   inst;
	logic [`CPU_XLEN-1:0]   seq_pc;      // Delay-slot address
	opcode_e                op;
	funct_e                 fn;
	logic                   busy1;       // rs waits on a load
	logic                   busy2;       // rt waits on a load
	logic [2:0]             f_valid;     // Index 0 is execute
	logic [2:0]             f_wen;
	logic [`CPU_REG_AW-1:0] f_num [3];
	logic [`CPU_XLEN-1:0]   f_data [3];
	ctrl_t                  ctrl;

	// Youngest matching write wins, result carries a not-ready flag on top
	function automatic logic [`CPU_XLEN:0] fwd_pick(input logic [`CPU_REG_AW-1:0] src,
		input logic [`CPU_XLEN-1:0] rf_data);
		logic [`CPU_XLEN:0] res;
		res = {1'b0, rf_data};
		for (int k = 2; k >= 0; k--)
			if (f_wen[k] && f_num[k] == src)
				res = {~f_valid[k], f_data[k]};
		return res;
	endfunction

	assign inst = hold_valid ? inst_hold : i_inst;  // SRAM word is gone after a stall
	assign op   = opcode_e'(inst[31:26]);
	assign fn   = funct_e'(inst[5:0]);

	assign f_valid = {i_wb_fwd.valid, i_mem_fwd.valid, i_ex_fwd.valid};
	assign f_wen   = {i_wb_fwd.wen, i_mem_fwd.wen, i_ex_fwd.wen};
	assign f_num   = '{i_ex_fwd.rnum, i_mem_fwd.rnum, i_wb_fwd.rnum};
	assign f_data  = '{i_ex_fwd.wdata, i_mem_fwd.wdata, i_wb_fwd.wdata};

	assign o_raddr1 = inst[25:21];
	assign o_raddr2 = inst[20:16];

	always_comb
	begin
		{busy1, o_op1} = fwd_pick(inst[25:21], i_rdata1);
		{busy2, o_op2} = fwd_pick(inst[20:16], i_rdata2);
	end

	assign o_valid    = id_valid & ~(busy1 | busy2);  // Load-use stall
	assign id_go      = o_valid & i_ex_allow_in;
	assign o_allow_in = ~id_valid | id_go;

	always_comb
	begin
		ctrl        = '0;
		ctrl.alu_op = ALU_ADD;
		ctrl.dest   = inst[20:16];  // rt for I-type
		case (op)
			OP_SPECIAL:
			begin
				ctrl.dest   = inst[15:11];  // rd
				ctrl.rf_wen = 1'b1;
				case (fn)
					FN_ADDU: ctrl.alu_op = ALU_ADD;
					FN_SUBU: ctrl.alu_op = ALU_SUB;
					FN_AND:  ctrl.alu_op = ALU_AND;
					FN_OR:   ctrl.alu_op = ALU_OR;
					FN_XOR:  ctrl.alu_op = ALU_XOR;
					FN_SLT:  ctrl.alu_op = ALU_SLT;
					default: ctrl.rf_wen = 1'b0;  // Unknown funct is a no-op
				endcase
			end
			OP_ADDIU:
			begin
				ctrl.use_imm = 1'b1;
				ctrl.rf_wen  = 1'b1;
			end
			OP_LUI:
			begin
				ctrl.alu_op  = ALU_LUI;
				ctrl.use_imm = 1'b1;
				ctrl.rf_wen  = 1'b1;
			end
			OP_LW:
			begin
				ctrl.use_imm = 1'b1;
				ctrl.rf_wen  = 1'b1;
				ctrl.load    = 1'b1;
			end
			OP_SW:
			begin
				ctrl.use_imm = 1'b1;
				ctrl.store   = 1'b1;
			end
			default: ;  // Branches, J and others write nothing
		endcase
		if (ctrl.dest == '0)
			ctrl.rf_wen = 1'b0;  // Register 0 stays zero
	end

	assign o_ctrl = ctrl;
	assign o_imm  = {{16{inst[15]}}, inst[15:0]};
	assign o_pc   = pc_id;
	assign seq_pc = pc_id + word_bytes;

	// Branch and jump resolve here, delay slot is already being fetched
	assign o_redirect = id_valid & ((op == OP_J) ||
		(op == OP_BEQ && o_op1 == o_op2) ||
		(op == OP_BNE && o_op1 != o_op2));
	assign o_target = (op == OP_J) ? {seq_pc[31:28], inst[25:0], 2'b00}
		: seq_pc + {o_imm[`CPU_XLEN-3:0], 2'b00};

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			id_valid   <= 1'b0;
			hold_valid <= 1'b0;
		end
		else
		begin
			id_valid   <= i_fetch_go | (id_valid & ~id_go);
			hold_valid <= id_valid & ~id_go;  // Set from second stall cycle on
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_fetch_go)
			pc_id <= i_pc;
		if (id_valid && !id_go && !hold_valid)
			inst_hold <= i_inst;  // Capture word on first stall cycle
	end

endmodule

//--- execute_stage.sv
`include "cpu_defs.svh"

module execute_stage (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 i_valid,
	input  cpu_pkg::ctrl_t       i_ctrl,
	input  logic [`CPU_XLEN-1:0] i_pc,
	input  logic [`CPU_XLEN-1:0] i_op1,
	input  logic [`CPU_XLEN-1:0] i_op2,
	input  logic [`CPU_XLEN-1:0] i_imm,
	input  logic                 i_mem_allow_in,
	output logic                 o_allow_in,
	fwd_if.src                   o_ex_fwd,
	output logic                 o_valid,
	output cpu_pkg::ctrl_t       o_ctrl,
	output logic [`CPU_XLEN-1:0] o_pc,
	output logic [`CPU_XLEN-1:0] o_result,
	output logic [`CPU_XLEN-1:0] o_store_data
);
	import cpu_pkg::*;

	logic                 ex_valid;
	logic                 ex_go;   // Hands off to memory stage
	ctrl_t                ex_ctrl;
	logic [`CPU_XLEN-1:0] ex_pc;
	logic [`CPU_XLEN-1:0] ex_op1;  // rs after forwarding
	logic [`CPU_XLEN-1:0] ex_op2;  // rt after forwarding
	logic [`CPU_XLEN-1:0] ex_imm;
	logic [`CPU_XLEN-1:0] alu_b;
	logic [`CPU_XLEN-1:0] alu_out;

	assign ex_go      = ex_valid & i_mem_allow_in;  // ALU is single cycle
	assign o_allow_in = ~ex_valid | ex_go;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			ex_valid <= 1'b0;
		else
			ex_valid <= (i_valid & o_allow_in) | (ex_valid & ~ex_go);
	end

	always_ff @(posedge clk)
	begin
		if (i_valid && o_allow_in)
		begin
			ex_ctrl <= i_ctrl;
			ex_pc   <= i_pc;
			ex_op1  <= i_op1;
			ex_op2  <= i_op2;
			ex_imm  <= i_imm;
		end
	end

	assign alu_b = ex_ctrl.use_imm ? ex_imm : ex_op2;

	always_comb
	begin
		case (ex_ctrl.alu_op)
			ALU_ADD: alu_out = ex_op1 + alu_b;
			ALU_SUB: alu_out = ex_op1 - alu_b;
			ALU_AND: alu_out = ex_op1 & alu_b;
			ALU_OR:  alu_out = ex_op1 | alu_b;
			ALU_XOR: alu_out = ex_op1 ^ alu_b;
			ALU_SLT: alu_out = {{(`CPU_XLEN-1){1'b0}}, $signed(ex_op1) < $signed(alu_b)};
			ALU_LUI: alu_out = {alu_b[15:0], 16'h0000};
			default: alu_out = '0;
		endcase
	end

	// Load address is no result, decode must wait for it
	assign o_ex_fwd.valid = ex_valid & ~ex_ctrl.load;
	assign o_ex_fwd.wen   = ex_valid & ex_ctrl.rf_wen;
	assign o_ex_fwd.rnum  = ex_ctrl.dest;
	assign o_ex_fwd.wdata = alu_out;

	assign o_valid      = ex_valid;
	assign o_ctrl       = ex_ctrl;
	assign o_pc         = ex_pc;
	assign o_result     = alu_out;  // Also the LW/SW address
	assign o_store_data = ex_op2;

endmodule

//--- mem_wb_stage.sv
`include "cpu_defs.svh"

module mem_wb_stage (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   i_valid,
	input  cpu_pkg::ctrl_t         i_ctrl,
	input  logic [`CPU_XLEN-1:0]   i_pc,
	input  logic [`CPU_XLEN-1:0]   i_result,
	input  logic [`CPU_XLEN-1:0]   i_store_data,
	output logic                   o_allow_in,
	fwd_if.src                     o_mem_fwd,
	fwd_if.src                     o_wb_fwd,
	output logic                   o_data_sram_en,
	output logic [`CPU_STRB_W-1:0] o_data_sram_wen,
	output logic [`CPU_XLEN-1:0]   o_data_sram_addr,
	output logic [`CPU_XLEN-1:0]   o_data_sram_wdata,
	input  logic [`CPU_XLEN-1:0]   i_data_sram_rdata,
	output logic [`CPU_XLEN-1:0]   o_debug_wb_pc,
	output logic [`CPU_STRB_W-1:0] o_debug_wb_rf_wen,
	output logic [`CPU_REG_AW-1:0] o_debug_wb_rf_wnum,
	output logic [`CPU_XLEN-1:0]   o_debug_wb_rf_wdata
);
	import cpu_pkg::*;

	logic                 mem_valid;
	logic                 mem_go;
	ctrl_t                mem_ctrl;
	logic [`CPU_XLEN-1:0] mem_pc;
	logic [`CPU_XLEN-1:0] mem_result;  // ALU value or data address
	logic [`CPU_XLEN-1:0] mem_wdata;
	logic                 wb_valid;
	ctrl_t                wb_ctrl;
	logic [`CPU_XLEN-1:0] wb_pc;
	logic [`CPU_XLEN-1:0] wb_result;
	logic [`CPU_XLEN-1:0] wb_data;     // Final register value

	assign mem_go     = mem_valid;  // WB retires every cycle
	assign o_allow_in = ~mem_valid | mem_go;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			mem_valid <= 1'b0;
			wb_valid  <= 1'b0;
		end
		else
		begin
			mem_valid <= (i_valid & o_allow_in) | (mem_valid & ~mem_go);
			wb_valid  <= mem_go;
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_valid && o_allow_in)
		begin
			mem_ctrl   <= i_ctrl;
			mem_pc     <= i_pc;
			mem_result <= i_result;
			mem_wdata  <= i_store_data;
		end
		if (mem_go)
		begin
			wb_ctrl   <= mem_ctrl;
			wb_pc     <= mem_pc;
			wb_result <= mem_result;
		end
	end

	// Word access only, read data shows up in WB
	assign o_data_sram_en    = mem_valid & (mem_ctrl.load | mem_ctrl.store);
	assign o_data_sram_wen   = {`CPU_STRB_W{mem_valid & mem_ctrl.store}};
	assign o_data_sram_addr  = mem_result;
	assign o_data_sram_wdata = mem_wdata;

	assign wb_data = wb_ctrl.load ? i_data_sram_rdata : wb_result;

	assign o_mem_fwd.valid = mem_valid & ~mem_ctrl.load;  // Load still waiting on SRAM
	assign o_mem_fwd.wen   = mem_valid & mem_ctrl.rf_wen;
	assign o_mem_fwd.rnum  = mem_ctrl.dest;
	assign o_mem_fwd.wdata = mem_result;

	assign o_wb_fwd.valid = wb_valid;
	assign o_wb_fwd.wen   = wb_valid & wb_ctrl.rf_wen;
	assign o_wb_fwd.rnum  = wb_ctrl.dest;
	assign o_wb_fwd.wdata = wb_data;

	assign o_debug_wb_pc       = wb_pc;
	assign o_debug_wb_rf_wen   = {`CPU_STRB_W{o_wb_fwd.wen}};
	assign o_debug_wb_rf_wnum  = wb_ctrl.dest;
	assign o_debug_wb_rf_wdata = wb_data;

endmodule

//--- cpu_top.sv
`include "cpu_defs.svh"

module cpu_top (
	input  logic                   clk,
	input  logic                   resetn,              // Active low
	output logic                   o_inst_sram_en,
	output logic [`CPU_STRB_W-1:0] o_inst_sram_wen,
	output logic [`CPU_XLEN-1:0]   o_inst_sram_addr,
	output logic [`CPU_XLEN-1:0]   o_inst_sram_wdata,
	input  logic [`CPU_XLEN-1:0]   i_inst_sram_rdata,
	output logic                   o_data_sram_en,
	output logic [`CPU_STRB_W-1:0] o_data_sram_wen,
	output logic [`CPU_XLEN-1:0]   o_data_sram_addr,
	output logic [`CPU_XLEN-1:0]   o_data_sram_wdata,
	input  logic [`CPU_XLEN-1:0]   i_data_sram_rdata,
	output logic [`CPU_XLEN-1:0]   o_debug_wb_pc,
	output logic [`CPU_STRB_W-1:0] o_debug_wb_rf_wen,
	output logic [`CPU_REG_AW-1:0] o_debug_wb_rf_wnum,
	output logic [`CPU_XLEN-1:0]   o_debug_wb_rf_wdata
);
	import cpu_pkg::*;

	logic                   fetch_go;
	logic [`CPU_XLEN-1:0]   if_pc;
	logic                   id_allow_in;
	logic                   id_valid;
	logic                   redirect;
	logic [`CPU_XLEN-1:0]   target;
	logic [`CPU_REG_AW-1:0] raddr1;
	logic [`CPU_REG_AW-1:0] raddr2;
	logic [`CPU_XLEN-1:0]   rdata1;
	logic [`CPU_XLEN-1:0]   rdata2;
	ctrl_t                  id_ctrl;
	logic [`CPU_XLEN-1:0]   id_pc;
	logic [`CPU_XLEN-1:0]   id_op1;
	logic [`CPU_XLEN-1:0]   id_op2;
	logic [`CPU_XLEN-1:0]   id_imm;
	logic                   ex_allow_in;
	logic                   ex_valid;
	ctrl_t                  ex_ctrl;
	logic [`CPU_XLEN-1:0]   ex_pc;
	logic [`CPU_XLEN-1:0]   ex_result;
	logic [`CPU_XLEN-1:0]   ex_store_data;
	logic                   mem_allow_in;

	fwd_if ex_fwd ();
	fwd_if mem_fwd ();
	fwd_if wb_fwd ();  // Also the register-file write port

	assign o_inst_sram_wen   = '0;  // Instruction memory is read only
	assign o_inst_sram_wdata = '0;

	fetch_stage fetch_stage_i (
		.clk              (clk),
		.resetn           (resetn),
		.i_id_allow_in    (id_allow_in),
		.i_redirect       (redirect),
		.i_target         (target),
		.o_fetch_go       (fetch_go),
		.o_pc             (if_pc),
		.o_inst_sram_en   (o_inst_sram_en),
		.o_inst_sram_addr (o_inst_sram_addr)
	);

	decode_stage decode_stage_i (
		.clk           (clk),
		.resetn        (resetn),
		.i_fetch_go    (fetch_go),
		.i_pc          (if_pc),
		.i_inst        (i_inst_sram_rdata),
		.i_rdata1      (rdata1),
		.i_rdata2      (rdata2),
		.o_raddr1      (raddr1),
		.o_raddr2      (raddr2),
		.i_ex_fwd      (ex_fwd.dst),
		.i_mem_fwd     (mem_fwd.dst),
		.i_wb_fwd      (wb_fwd.dst),
		.i_ex_allow_in (ex_allow_in),
		.o_allow_in    (id_allow_in),
		.o_valid       (id_valid),
		.o_redirect    (redirect),
		.o_target      (target),
		.o_ctrl        (id_ctrl),
		.o_pc          (id_pc),
		.o_op1         (id_op1),
		.o_op2         (id_op2),
		.o_imm         (id_imm)
	);

	execute_stage execute_stage_i (
		.clk            (clk),
		.resetn         (resetn),
		.i_valid        (id_valid),
		.i_ctrl         (id_ctrl),
		.i_pc           (id_pc),
		.i_op1          (id_op1),
		.i_op2          (id_op2),
		.i_imm          (id_imm),
		.i_mem_allow_in (mem_allow_in),
		.o_allow_in     (ex_allow_in),
		.o_ex_fwd       (ex_fwd.src),
		.o_valid        (ex_valid),
		.o_ctrl         (ex_ctrl),
		.o_pc           (ex_pc),
		.o_result       (ex_result),
		.o_store_data   (ex_store_data)
	);

	mem_wb_stage mem_wb_stage_i (
		.clk                 (clk),
		.resetn              (resetn),
		.i_valid             (ex_valid),
		.i_ctrl              (ex_ctrl),
		.i_pc                (ex_pc),
		.i_result            (ex_result),
		.i_store_data        (ex_store_data),
		.o_allow_in          (mem_allow_in),
		.o_mem_fwd           (mem_fwd.src),
		.o_wb_fwd            (wb_fwd.src),
		.o_data_sram_en      (o_data_sram_en),
		.o_data_sram_wen     (o_data_sram_wen),
		.o_data_sram_addr    (o_data_sram_addr),
		.o_data_sram_wdata   (o_data_sram_wdata),
		.i_data_sram_rdata   (i_data_sram_rdata),
		.o_debug_wb_pc       (o_debug_wb_pc),
		.o_debug_wb_rf_wen   (o_debug_wb_rf_wen),
		.o_debug_wb_rf_wnum  (o_debug_wb_rf_wnum),
		.o_debug_wb_rf_wdata (o_debug_wb_rf_wdata)
	);

	reg_file reg_file_i (
		.clk      (clk),
		.resetn   (resetn),
		.i_raddr1 (raddr1),
		.i_raddr2 (raddr2),
		.o_rdata1 (rdata1),
		.o_rdata2 (rdata2),
		.i_wb     (wb_fwd.dst)
	);

endmodule

//--- cpu_assert.sv
`include "cpu_defs.svh"

module cpu_assert (
	input logic                   clk,
	input logic                   resetn,
	input logic                   o_data_sram_en,
	input logic [`CPU_XLEN-1:0]   o_data_sram_addr,
	input logic [`CPU_STRB_W-1:0] o_debug_wb_rf_wen,
	input logic [`CPU_REG_AW-1:0] o_debug_wb_rf_wnum,
	input logic [`CPU_XLEN-1:0]   o_debug_wb_rf_wdata
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;  // Failed assertions so far

	// Word accesses only
	word_aligned: assert property (@(posedge clk) disable iff (!resetn)
		o_data_sram_en |-> o_data_sram_addr[1:0] == 2'b00)
		else
		begin
			fail_count++;
			$error("unaligned data SRAM address");
		end

	// Register 0 never shows
	wb_no_r0: assert property (@(posedge clk) disable iff (!resetn)
		o_debug_wb_rf_wen != '0 |-> o_debug_wb_rf_wnum != '0)
		else
		begin
			fail_count++;
			$error("debug write to register 0");
		end

	// Written value is always known
	wb_known: assert property (@(posedge clk) disable iff (!resetn)
		o_debug_wb_rf_wen != '0 |-> !$isunknown(o_debug_wb_rf_wdata))
		else
		begin
			fail_count++;
			$error("debug write data has unknown bits");
		end

endmodule

bind cpu_top cpu_assert cpu_assert_i (.*);

//--- tb_cpu.sv
`include "cpu_defs.svh"

module tb_cpu;
	timeunit 1ns;
	timeprecision 1ps;

	import cpu_pkg::*;

	localparam int total_insts = 43;                 // Sum of all program lengths
	localparam int cycle_limit = 60 * total_insts;
	localparam int mem_words   = 1024;

	logic                   clk;
	logic                   resetn;
	logic                   inst_en;
	logic [`CPU_STRB_W-1:0] inst_wen;
	logic [`CPU_XLEN-1:0]   inst_addr;
	logic [`CPU_XLEN-1:0]   inst_wdata;
	logic [`CPU_XLEN-1:0]   inst_rdata;
	logic                   data_en;
	logic [`CPU_STRB_W-1:0] data_wen;
	logic [`CPU_XLEN-1:0]   data_addr;
	logic [`CPU_XLEN-1:0]   data_wdata;
	logic [`CPU_XLEN-1:0]   data_rdata;
	logic [`CPU_XLEN-1:0]   wb_pc;
	logic [`CPU_STRB_W-1:0] wb_wen;
	logic [`CPU_REG_AW-1:0] wb_wnum;
	logic [`CPU_XLEN-1:0]   wb_wdata;

	logic [`CPU_XLEN-1:0]   imem [mem_words];
	logic [`CPU_XLEN-1:0]   dmem [mem_words];
	logic                   inst_en_q;                // Fetch requested at last rising edge
	logic [`CPU_XLEN-1:0]   inst_addr_q;              // Address of last fetch
	logic [`CPU_XLEN-1:0]   data_addr_q;              // Address of last load
	int                     prog_len;
	int                     cycles;
	int                     errors;
	int                     tests_failed;

	logic [`CPU_XLEN-1:0]   got_pc [$];               // Observed write-backs
	logic [`CPU_REG_AW-1:0] got_num [$];
	logic [`CPU_XLEN-1:0]   got_data [$];
	logic [`CPU_XLEN-1:0]   got_st_addr [$];          // Observed stores
	logic [`CPU_XLEN-1:0]   got_st_data [$];
	logic [`CPU_STRB_W-1:0] got_st_strb [$];
	logic [`CPU_XLEN-1:0]   exp_pc [$];               // Reference model output
	logic [`CPU_REG_AW-1:0] exp_num [$];
	logic [`CPU_XLEN-1:0]   exp_data [$];
	logic [`CPU_XLEN-1:0]   exp_st_addr [$];
	logic [`CPU_XLEN-1:0]   exp_st_data [$];

	cpu_top cpu_top_i (
		.clk                 (clk),
		.resetn              (resetn),
		.o_inst_sram_en      (inst_en),
		.o_inst_sram_wen     (inst_wen),
		.o_inst_sram_addr    (inst_addr),
		.o_inst_sram_wdata   (inst_wdata),
		.i_inst_sram_rdata   (inst_rdata),
		.o_data_sram_en      (data_en),
		.o_data_sram_wen     (data_wen),
		.o_data_sram_addr    (data_addr),
		.o_data_sram_wdata   (data_wdata),
		.i_data_sram_rdata   (data_rdata),
		.o_debug_wb_pc       (wb_pc),
		.o_debug_wb_rf_wen   (wb_wen),
		.o_debug_wb_rf_wnum  (wb_wnum),
		.o_debug_wb_rf_wdata (wb_wdata)
	);

	always #20 clk = ~clk;  // 40 ns period

	// Global watchdog
	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			$display("Timeout: no end of test after %0d cycles", cycles);
			$display("Something failed");
			$finish;
		end
	end

	// SRAM models, request at rising edge, answer at falling edge
	always @(posedge clk)
	begin
		inst_en_q <= inst_en;
		if (inst_en)
			inst_addr_q <= inst_addr;  // Held while fetch stalls
		if (data_en && data_wen == '0)
			data_addr_q <= data_addr;
		if (data_en && data_wen != '0)
			dmem[data_addr[11:2]] <= data_wdata;  // Full word only
	end

	always @(negedge clk)
	begin
		inst_rdata <= inst_en_q ? imem[inst_addr_q[11:2]] : 'x;  // No request, no word
		data_rdata <= dmem[data_addr_q[11:2]];
	end

	// Trace of write-backs and stores
	always @(posedge clk)
	begin
		if (resetn && wb_wen != '0)
		begin
			got_pc.push_back(wb_pc);
			got_num.push_back(wb_wnum);
			got_data.push_back(wb_wdata);
		end
		if (resetn && data_en && data_wen != '0)
		begin
			got_st_addr.push_back(data_addr);
			got_st_data.push_back(data_wdata);
			got_st_strb.push_back(data_wen);
		end
	end

	function automatic logic [`CPU_XLEN-1:0] r_enc(funct_e fn, int rd, int rs, int rt);
		return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	function automatic logic [`CPU_XLEN-1:0] i_enc(opcode_e op, int rt, int rs,
		logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	function automatic logic [`CPU_XLEN-1:0] j_enc(logic [`CPU_XLEN-1:0] dest);
		return {OP_J, dest[27:2]};
	endfunction

	// Data pattern over the whole address
	function automatic logic [`CPU_XLEN-1:0] fill_word(logic [`CPU_XLEN-1:0] addr);
		return (addr * 32'h9e3779b1) ^ 32'h13572468;
	endfunction

	task automatic check_word(string name, logic [`CPU_XLEN-1:0] exp,
		logic [`CPU_XLEN-1:0] act);
		if (exp !== act)
		begin
			$display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_regnum(string name, logic [`CPU_REG_AW-1:0] exp,
		logic [`CPU_REG_AW-1:0] act);
		if (exp !== act)
		begin
			$display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_strb(string name, logic [`CPU_STRB_W-1:0] exp,
		logic [`CPU_STRB_W-1:0] act);
		if (exp !== act)
		begin
			$display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		if (exp !== act)
		begin
			$display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
			errors++;
		end
	endtask

	task automatic new_program();
		for (int k = 0; k < mem_words; k++)
		begin
			imem[k] = '0;  // SPECIAL funct 0 writes nothing
			dmem[k] = fill_word(k * 4);
		end
		prog_len = 0;
	endtask

	task automatic put(logic [`CPU_XLEN-1:0] inst);
		imem[prog_len] = inst;
		prog_len++;
	endtask

	// Instruction-level model with one delay slot
	task automatic reference_run();
		logic [`CPU_XLEN-1:0]   r [`CPU_NREGS];
		logic [`CPU_XLEN-1:0]   dm [mem_words];
		logic [`CPU_XLEN-1:0]   pc;
		logic [`CPU_XLEN-1:0]   npc;
		logic [`CPU_XLEN-1:0]   nxt;
		logic [`CPU_XLEN-1:0]   inst;
		logic [`CPU_XLEN-1:0]   a;
		logic [`CPU_XLEN-1:0]   b;
		logic [`CPU_XLEN-1:0]   simm;
		logic [`CPU_XLEN-1:0]   val;
		logic [`CPU_XLEN-1:0]   addr;
		logic [`CPU_REG_AW-1:0] dst;
		logic                   wr;
		int                     steps;
		exp_pc.delete();
		exp_num.delete();
		exp_data.delete();
		exp_st_addr.delete();
		exp_st_data.delete();
		for (int k = 0; k < `CPU_NREGS; k++)
			r[k] = '0;
		for (int k = 0; k < mem_words; k++)
			dm[k] = dmem[k];
		pc    = `CPU_RESET_PC;
		npc   = pc + 4;
		steps = 0;
		while (pc - `CPU_RESET_PC < 4 * prog_len && steps < 500)
		begin
			inst = imem[pc[11:2]];
			a    = r[inst[25:21]];
			b    = r[inst[20:16]];
			simm = {{16{inst[15]}}, inst[15:0]};
			nxt  = npc + 4;
			wr   = 1'b1;
			dst  = inst[20:16];  // rt unless R-type
			val  = '0;
			addr = a + simm;
			case (opcode_e'(inst[31:26]))
				OP_SPECIAL:
				begin
					dst = inst[15:11];
					case (funct_e'(inst[5:0]))
						FN_ADDU: val = a + b;
						FN_SUBU: val = a - b;
						FN_AND:  val = a & b;
						FN_OR:   val = a | b;
						FN_XOR:  val = a ^ b;
						FN_SLT:  val = ($signed(a) < $signed(b)) ? 1 : 0;
						default: wr = 1'b0;
					endcase
				end
				OP_ADDIU: val = a + simm;
				OP_LUI:   val = {inst[15:0], 16'h0000};
				OP_LW:    val = dm[addr[11:2]];
				OP_SW:
				begin
					wr = 1'b0;
					dm[addr[11:2]] = b;
					exp_st_addr.push_back(addr);
					exp_st_data.push_back(b);
				end
				OP_BEQ:
				begin
					wr = 1'b0;
					if (a == b)
						nxt = npc + (simm << 2);  // Relative to delay slot
				end
				OP_BNE:
				begin
					wr = 1'b0;
					if (a != b)
						nxt = npc + (simm << 2);
				end
				OP_J:
				begin
					wr  = 1'b0;
					nxt = {npc[31:28], inst[25:0], 2'b00};
				end
				default: wr = 1'b0;
			endcase
			if (wr && dst != 0)
			begin
				r[dst] = val;
				exp_pc.push_back(pc);
				exp_num.push_back(dst);
				exp_data.push_back(val);
			end
			pc  = npc;
			npc = nxt;
			steps++;
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		resetn = 1'b0;
		got_pc.delete();
		got_num.delete();
		got_data.delete();
		got_st_addr.delete();
		got_st_data.delete();
		got_st_strb.delete();
		repeat (2) @(negedge clk);
		resetn = 1'b1;
	endtask

	// Wait for all expected write-backs, then a quiet tail
	task automatic finish_program(string name);
		int start_errors;
		start_errors = errors;
		while (got_num.size() < exp_num.size())
			@(negedge clk);
		repeat (8) @(negedge clk);  // Catch stray writes
		if (got_num.size() != exp_num.size())
		begin
			$display("%s saw %0d write-backs where %0d were due", name,
				got_num.size(), exp_num.size());
			errors++;
		end
		else
			for (int k = 0; k < exp_num.size(); k++)
			begin
				check_word("o_debug_wb_pc", exp_pc[k], got_pc[k]);
				check_regnum("o_debug_wb_rf_wnum", exp_num[k], got_num[k]);
				check_word("o_debug_wb_rf_wdata", exp_data[k], got_data[k]);
			end
		if (got_st_addr.size() != exp_st_addr.size())
		begin
			$display("%s saw %0d stores where %0d were due", name,
				got_st_addr.size(), exp_st_addr.size());
			errors++;
		end
		else
			for (int k = 0; k < exp_st_addr.size(); k++)
			begin
				check_word("o_data_sram_addr", exp_st_addr[k], got_st_addr[k]);
				check_word("o_data_sram_wdata", exp_st_data[k], got_st_data[k]);
				check_strb("o_data_sram_wen", 4'hf, got_st_strb[k]);
			end
		if (errors == start_errors)
			$display("test %s: passed", name);
		else
		begin
			$display("test %s: failed with %0d errors", name, errors - start_errors);
			tests_failed++;
		end
	endtask

	task automatic test_reset();
		new_program();
		put(i_enc(OP_ADDIU, 1, 0, 16'd5));
		put(i_enc(OP_ADDIU, 2, 1, 16'd7));  // Forward from execute
		reference_run();
		apply_reset();
		check_bit("o_inst_sram_en", 1'b1, inst_en);
		check_word("o_inst_sram_addr", `CPU_RESET_PC, inst_addr);
		while (wb_wen == '0)
		begin
			check_bit("o_data_sram_en", 1'b0, data_en);
			check_strb("o_inst_sram_wen", 4'h0, inst_wen);  // Instruction port is read only
			check_word("o_inst_sram_wdata", '0, inst_wdata);
			@(negedge clk);
		end
		finish_program("reset");
	endtask

	task automatic test_alu_chain();
		new_program();
		put(i_enc(OP_ADDIU, 1, 0, 16'h1234));
		put(i_enc(OP_ADDIU, 2, 1, 16'hfffb));  // Negative immediate
		put(r_enc(FN_ADDU, 3, 1, 2));
		put(r_enc(FN_SUBU, 4, 3, 1));
		put(r_enc(FN_AND, 5, 4, 3));
		put(r_enc(FN_OR, 6, 5, 2));
		put(r_enc(FN_XOR, 7, 6, 5));
		put(r_enc(FN_SLT, 8, 7, 6));
		put(i_enc(OP_LUI, 9, 0, 16'h8001));
		put(r_enc(FN_SLT, 10, 9, 8));          // Negative operand
		put(r_enc(FN_XOR, 11, 10, 9));
		reference_run();
		apply_reset();
		finish_program("alu_chain");
	endtask

	task automatic test_load_store();
		new_program();
		put(i_enc(OP_ADDIU, 1, 0, 16'h0100));
		put(i_enc(OP_LUI, 2, 0, 16'hcafe));
		put(i_enc(OP_ADDIU, 2, 2, 16'h1234));
		put(i_enc(OP_SW, 2, 1, 16'd8));
		put(i_enc(OP_LW, 3, 1, 16'd8));        // Reads back the store
		put(r_enc(FN_ADDU, 4, 3, 1));          // Load-use stall
		put(i_enc(OP_LW, 5, 1, 16'd12));       // Fill pattern word
		put(i_enc(OP_ADDIU, 6, 5, 16'd1));
		put(i_enc(OP_SW, 6, 1, 16'hfffc));
		reference_run();
		apply_reset();
		finish_program("load_store");
	endtask

	task automatic test_control_flow();
		new_program();
		put(i_enc(OP_ADDIU, 1, 0, 16'd1));
		put(i_enc(OP_ADDIU, 2, 0, 16'd1));
		put(i_enc(OP_BEQ, 2, 1, 16'd3));       // Taken to 6
		put(i_enc(OP_ADDIU, 3, 0, 16'd3));     // Delay slot
		put(i_enc(OP_ADDIU, 4, 0, 16'd4));
		put(i_enc(OP_ADDIU, 5, 0, 16'd5));
		put(i_enc(OP_BNE, 2, 1, 16'd5));       // Not taken
		put(i_enc(OP_ADDIU, 6, 0, 16'd6));
		put(i_enc(OP_BEQ, 0, 1, 16'd5));       // Not taken
		put(i_enc(OP_ADDIU, 7, 0, 16'd7));
		put(j_enc(`CPU_RESET_PC + 13 * 4));
		put(i_enc(OP_ADDIU, 8, 0, 16'd8));
		put(i_enc(OP_ADDIU, 9, 0, 16'd9));     // Jumped over
		put(i_enc(OP_BNE, 0, 1, 16'd2));       // Taken to 16
		put(i_enc(OP_ADDIU, 10, 0, 16'd10));
		put(i_enc(OP_ADDIU, 11, 0, 16'd11));
		put(i_enc(OP_ADDIU, 12, 1, 16'd12));
		reference_run();
		apply_reset();
		finish_program("control_flow");
	endtask

	task automatic test_reg_zero();
		new_program();
		put(i_enc(OP_ADDIU, 0, 0, 16'h0055));  // Must not write
		put(r_enc(FN_ADDU, 1, 0, 0));
		put(i_enc(OP_ADDIU, 2, 0, 16'd7));
		put(r_enc(FN_OR, 3, 0, 2));
		reference_run();
		apply_reset();
		finish_program("reg_zero");
	endtask

	initial
	begin
		clk          = 1'b0;
		resetn       = 1'b0;
		inst_rdata   = '0;
		data_rdata   = '0;
		inst_en_q    = 1'b0;
		inst_addr_q  = `CPU_RESET_PC;
		data_addr_q  = '0;
		cycles       = 0;
		errors       = 0;
		tests_failed = 0;
		test_reset();
		test_alu_chain();
		test_load_store();
		test_control_flow();
		test_reg_zero();
		errors += cpu_top_i.cpu_assert_i.fail_count;  // Assertion failures count too
		$display("tests run 5, failed %0d, errors %0d", tests_failed, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+.
cpu_pkg.sv
fwd_if.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
cpu_top.sv
cpu_assert.sv
tb_cpu.sv

//--- Bender.yml
package:
  name: cpu

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - fwd_if.sv
      - reg_file.sv
      - fetch_stage.sv
      - decode_stage.sv
      - execute_stage.sv
      - mem_wb_stage.sv
      - cpu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - cpu_assert.sv
      - tb_cpu.sv
